// File: all.f
source/edpPkg.sv
source/edpAdder.sv
source/edpFastMem.sv
source/edpWorkRegs.sv
source/edp.sv
sim/edp_assertions.sv
sim/edpTb.sv

// File: run.sh
#!/bin/sh
# Build the EDP testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f all.f --top-module edpTb -Mdir obj_dir -o edpSim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/edpSim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
exit 0

// File: sim/edpTb.sv
`default_nettype none

module edpTb import edpPkg::*; ();

  timeunit 1ns;
  timeprecision 1ns;

  localparam int maxCycles = 400;                 // Several times the test length

  logic        clk;
  logic        rst;
  tAdFunc      adFunc;
  tAdaSel      adaSel;
  tAdbSel      adbSel;
  logic        adCarryIn;
  tArSel       arlSel;
  tArSel       arrSel;
  tArSel       arxlSel;
  tArSel       arxrSel;
  logic        brLoad;
  logic        brxLoad;
  tMqSel       mqSel;
  logic        fmWriteLeft;
  logic        fmWriteRight;
  logic        adToEbusLeft;
  logic        adToEbusRight;
  logic [2:0]  fmBlock;
  logic [3:0]  fmAdr;
  logic [35:0] cacheData;
  logic [35:0] ebusIn;
  logic [35:0] pc;
  logic [37:0] ad;
  logic        adCarryOut;
  logic [35:0] ar;
  logic [35:0] arx;
  logic [35:0] br;
  logic [35:0] brx;
  logic [35:0] mq;
  logic [35:0] ebusOut;
  int          seed;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  edp #(.fmBlocks(8)) i_dut (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > maxCycles) begin
      $display("Timeout: tests did not finish within %0d clock cycles", maxCycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic checkValue(string name, logic [37:0] expected, logic [37:0] actual);
    checks = checks + 1;
    if (actual !== expected) begin
      errors = errors + 1;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  function automatic logic [37:0] widen(logic [35:0] w);
    return {2'b00, w};
  endfunction

  function automatic logic [37:0] signExt(logic [35:0] w);
    return {w[35], w[35], w};
  endfunction

  function automatic logic [35:0] randWord();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[35:0];
  endfunction

  // Expected {carry, AD} from the 38-bit sign-extended rule
  function automatic logic [38:0] adderModel(tAdFunc f, logic [35:0] a, logic [37:0] b,
                                             logic cin);
    logic [37:0] aExt;
    logic [37:0] cinVal;
    logic [37:0] res;
    logic [37:0] low;
    logic        arith;
    aExt   = signExt(a);
    arith  = (f == adAPlusB) || (f == adAMinusB);
    cinVal = (arith && cin) ? 38'd1 : 38'd0;
    low    = '0;
    case (f)
      adA:       res = aExt;
      adB:       res = b;
      adAPlusB:  res = aExt + b + cinVal;
      adAMinusB: res = aExt - b + cinVal;
      adAnd:     res = aExt & b;
      adOr:      res = aExt | b;
      adXor:     res = aExt ^ b;
      default:   res = '0;
    endcase
    if (f == adAPlusB) low = widen(a) + widen(b[35:0]) + cinVal;
    if (f == adAMinusB) low = widen(a) + widen(~b[35:0]) + 38'd1 + cinVal;
    return {low > 38'h0F_FFFF_FFFF, res};         // Carry when the word overflows
  endfunction

  task automatic tick();
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic settle();
    #10;
  endtask

  task automatic holdAll();
    adFunc        = adZero;
    adaSel        = adaAR;
    adbSel        = adbBR;
    adCarryIn     = 1'b0;
    arlSel        = arHold;
    arrSel        = arHold;
    arxlSel       = arHold;
    arxrSel       = arHold;
    brLoad        = 1'b0;
    brxLoad       = 1'b0;
    mqSel         = mqHold;
    fmWriteLeft   = 1'b0;
    fmWriteRight  = 1'b0;
    adToEbusLeft  = 1'b0;
    adToEbusRight = 1'b0;
  endtask

  task automatic loadArFromCache(logic [35:0] w);
    cacheData = w;
    arlSel    = arCache;
    arrSel    = arCache;
    tick();
    holdAll();
    checkValue("ar from cache", widen(w), widen(ar));
  endtask

  task automatic resetTest();
    checkValue("reset ar", 38'd0, widen(ar));
    checkValue("reset arx", 38'd0, widen(arx));
    checkValue("reset br", 38'd0, widen(br));
    checkValue("reset brx", 38'd0, widen(brx));
    checkValue("reset mq", 38'd0, widen(mq));
    checkValue("reset ebusOut", 38'd0, widen(ebusOut));
  endtask

  task automatic adderFuncTest();
    logic [35:0] a;
    logic [35:0] b;
    logic [38:0] exp;
    for (int round = 0; round < 2; round++) begin
      a = randWord();
      b = randWord();
      loadArFromCache(b);
      brLoad = 1'b1;
      tick();
      brLoad = 1'b0;
      checkValue("br copy of ar", widen(b), widen(br));
      loadArFromCache(a);
      for (int f = 0; f < 8; f++) begin
        for (int c = 0; c < 2; c++) begin
          adFunc    = tAdFunc'(f[2:0]);
          adCarryIn = c[0];
          settle();
          exp = adderModel(adFunc, a, signExt(b), adCarryIn);
          checkValue($sformatf("adder func %0d cin %0d ad", f, c), exp[37:0], ad);
          checkValue($sformatf("adder func %0d cin %0d carry", f, c),
                     {37'd0, exp[38]}, {37'd0, adCarryOut});
          @(negedge clk);
        end
      end
      holdAll();
    end
  endtask

  task automatic shiftedBrTest();
    logic [35:0] m;
    logic [35:0] b;
    logic [38:0] exp;
    m = randWord();
    b = randWord();
    loadArFromCache(m);
    adFunc = adA;
    mqSel  = mqAD;
    tick();
    holdAll();
    checkValue("mq load from ad", widen(m), widen(mq));
    loadArFromCache(b);
    brLoad = 1'b1;
    tick();
    for (int f = 0; f < 8; f++) begin
      holdAll();
      adFunc    = tAdFunc'(f[2:0]);
      adaSel    = adaMQ;
      adbSel    = adbBRx2;
      adCarryIn = 1'b1;
      settle();
      exp = adderModel(adFunc, m, signExt(b) << 1, 1'b1);  // BR times two
      checkValue($sformatf("mq and 2br func %0d ad", f), exp[37:0], ad);
      checkValue($sformatf("mq and 2br func %0d carry", f), {37'd0, exp[38]},
                 {37'd0, adCarryOut});
      @(negedge clk);
    end
    holdAll();
  endtask

  task automatic fastMemTest();
    logic [35:0] words [4];
    logic [35:0] w;
    logic [2:0]  blks [4];
    logic [3:0]  adrs [4];
    blks = '{3'd0, 3'd3, 3'd5, 3'd7};
    adrs = '{4'd0, 4'd9, 4'd15, 4'd4};
    for (int k = 0; k < 4; k++) begin
      words[k] = randWord();
      loadArFromCache(words[k]);
      fmBlock      = blks[k];
      fmAdr        = adrs[k];
      fmWriteLeft  = 1'b1;
      fmWriteRight = 1'b1;
      tick();
      holdAll();
    end
    // Half writes must keep the other half
    w = randWord();
    loadArFromCache(w);
    fmBlock     = blks[0];
    fmAdr       = adrs[0];
    fmWriteLeft = 1'b1;
    tick();
    holdAll();
    words[0]     = {w[35:18], words[0][17:0]};
    fmBlock      = blks[1];
    fmAdr        = adrs[1];
    fmWriteRight = 1'b1;
    tick();
    holdAll();
    words[1] = {words[1][35:18], w[17:0]};
    for (int k = 0; k < 4; k++) begin
      fmBlock = blks[k];
      fmAdr   = adrs[k];
      adFunc  = adB;
      adbSel  = adbFM;
      arlSel  = arFM;
      arrSel  = arFM;
      settle();
      checkValue($sformatf("fm read %0d via ad", k), signExt(words[k]), ad);
      tick();
      holdAll();
      checkValue($sformatf("fm read %0d into ar", k), widen(words[k]), widen(ar));
    end
  endtask

  task automatic halfSelectTest();
    logic [35:0] cw;
    logic [35:0] ew;
    logic [35:0] expAr;
    logic [35:0] expArx;
    logic [35:0] expMq;
    cw        = randWord();
    ew        = randWord() | 36'h1;               // LSB set so the MQ shift sees a one
    cacheData = cw;
    ebusIn    = ew;
    arlSel    = arEbus;
    arrSel    = arClr;
    arxlSel   = arCache;
    arxrSel   = arEbus;
    tick();
    holdAll();
    expAr  = {ew[35:18], 18'd0};
    expArx = {cw[35:18], ew[17:0]};
    checkValue("ar bus left clear right", widen(expAr), widen(ar));
    checkValue("arx cache left bus right", widen(expArx), widen(arx));
    adFunc  = adB;
    adbSel  = adbARX;
    arrSel  = arAD;
    arxlSel = arClr;
    brxLoad = 1'b1;
    tick();
    holdAll();
    checkValue("brx copy of arx", widen(expArx), widen(brx));
    expAr  = {expAr[35:18], expArx[17:0]};
    expArx = {18'd0, expArx[17:0]};
    checkValue("ar hold left ad right", widen(expAr), widen(ar));
    checkValue("arx clear left hold right", widen(expArx), widen(arx));
    adFunc = adA;
    mqSel  = mqAD;
    tick();
    holdAll();
    expMq = expAr;
    checkValue("mq load", widen(expMq), widen(mq));
    adFunc = adA;
    adaSel = adaARX;
    mqSel  = mqShift;
    tick();
    holdAll();
    expMq = {expArx[0], expMq[35:1]};             // AD LSB enters at the sign end
    checkValue("mq shift", widen(expMq), widen(mq));
    mqSel = mqClr;
    tick();
    holdAll();
    checkValue("mq clear", 38'd0, widen(mq));
  endtask

  task automatic ebusTest();
    logic [35:0] p;
    logic [35:0] expBus;
    p      = randWord();
    pc     = p;
    adFunc = adA;
    adaSel = adaPC;
    for (int en = 0; en < 4; en++) begin
      adToEbusLeft  = en[1];
      adToEbusRight = en[0];
      settle();
      expBus = {en[1] ? p[35:18] : 18'd0, en[0] ? p[17:0] : 18'd0};
      checkValue($sformatf("ad from pc, enables %0d", en), signExt(p), ad);
      checkValue($sformatf("ebusOut, enables %0d", en), widen(expBus), widen(ebusOut));
      @(negedge clk);
    end
    holdAll();
  endtask

  initial begin
    seed      = 32'h7340a549;
    rst       = 1'b1;
    holdAll();
    fmBlock   = '0;
    fmAdr     = '0;
    cacheData = '0;
    ebusIn    = '0;
    pc        = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    resetTest();
    adderFuncTest();
    shiftedBrTest();
    fastMemTest();
    halfSelectTest();
    ebusTest();
    $display("Checks: %0d, check errors: %0d, assertion failures: %0d",
             checks, errors, i_dut.assertChecks.fails);
    if (errors == 0 && i_dut.assertChecks.fails == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/edp_assertions.sv
`default_nettype none

module edp_assertions import edpPkg::*; (
  input logic  clk,
  input logic  rst,
  input tArSel arlSel,
  input tArSel arrSel,
  input tWord  ar,
  input tWord  arx,
  input tWord  br,
  input tWord  brx,
  input tWord  mq
);

  timeunit 1ns;
  timeprecision 1ns;

  int fails = 0;                                  // Failed assertion count

  property regsClearAfterReset;
    @(posedge clk) rst |=> (ar == '0 && arx == '0 && br == '0 && brx == '0 && mq == '0);
  endproperty

  property arHoldKeepsValue;
    @(posedge clk) disable iff (rst)
      (arlSel == arHold && arrSel == arHold) |=> (ar == $past(ar));
  endproperty

  resetClear: assert property (regsClearAfterReset)
    else begin
      fails = fails + 1;
      $error("Work registers not zero in the cycle after reset");
    end

  arHoldStable: assert property (arHoldKeepsValue)
    else begin
      fails = fails + 1;
      $error("AR changed while both half selects were hold");
    end

endmodule

bind edp edp_assertions assertChecks (.*);

`default_nettype wire

// File: source/edp.sv
`default_nettype none

module edp import edpPkg::*; #(
  parameter int fmBlocks = 8
) (
  input  logic                   clk,
  input  logic                   rst,
  input  tAdFunc                 adFunc,
  input  tAdaSel                 adaSel,
  input  tAdbSel                 adbSel,
  input  logic                   adCarryIn,
  input  tArSel                  arlSel,
  input  tArSel                  arrSel,
  input  tArSel                  arxlSel,
  input  tArSel                  arxrSel,
  input  logic                   brLoad,
  input  logic                   brxLoad,
  input  tMqSel                  mqSel,
  input  logic                   fmWriteLeft,
  input  logic                   fmWriteRight,
  input  logic                   adToEbusLeft,
  input  logic                   adToEbusRight,
  input  logic [fmBlockBits-1:0] fmBlock,
  input  logic [fmAdrBits-1:0]   fmAdr,
  input  tWord                   cacheData,
  input  tWord                   ebusIn,
  input  tWord                   pc,
  output tAdWord                 ad,
  output logic                   adCarryOut,
  output tWord                   ar,
  output tWord                   arx,
  output tWord                   br,
  output tWord                   brx,
  output tWord                   mq,
  output tWord                   ebusOut
);

  tWord fmData;                                   // Current FM word, shared by AD and AR

  edpAdder adder (
    .adFunc     (adFunc),
    .adaSel     (adaSel),
    .adbSel     (adbSel),
    .adCarryIn  (adCarryIn),
    .ar         (ar),
    .arx        (arx),
    .mq         (mq),
    .br         (br),
    .fmData     (fmData),
    .pc         (pc),
    .ad         (ad),
    .adCarryOut (adCarryOut)
  );

  edpWorkRegs workRegs (
    .clk       (clk),
    .rst       (rst),
    .arlSel    (arlSel),
    .arrSel    (arrSel),
    .arxlSel   (arxlSel),
    .arxrSel   (arxrSel),
    .brLoad    (brLoad),
    .brxLoad   (brxLoad),
    .mqSel     (mqSel),
    .ad        (ad),
    .fmData    (fmData),
    .cacheData (cacheData),
    .ebusIn    (ebusIn),
    .ar        (ar),
    .arx       (arx),
    .br        (br),
    .brx       (brx),
    .mq        (mq)
  );

  edpFastMem #(
    .fmBlocks (fmBlocks)
  ) fastMem (
    .clk          (clk),
    .fmBlock      (fmBlock),
    .fmAdr        (fmAdr),
    .writeData    (ar),                           // ACs are always written from AR
    .fmWriteLeft  (fmWriteLeft),
    .fmWriteRight (fmWriteRight),
    .fmData       (fmData)
  );

  // Each bus half is driven only while its enable is up
  assign ebusOut[0:halfBits-1]        = adToEbusLeft  ? ad[0:17]  : '0;
  assign ebusOut[halfBits:wordBits-1] = adToEbusRight ? ad[18:35] : '0;

endmodule

`default_nettype wire

// File: source/edpAdder.sv
`default_nettype none

module edpAdder import edpPkg::*; (
  input  tAdFunc adFunc,
  input  tAdaSel adaSel,
  input  tAdbSel adbSel,
  input  logic   adCarryIn,
  input  tWord   ar,
  input  tWord   arx,
  input  tWord   mq,
  input  tWord   br,
  input  tWord   fmData,
  input  tWord   pc,
  output tAdWord ad,
  output logic   adCarryOut
);

  tWord        aOp;
  tAdWord      aExt;
  tAdWord      bExt;
  tAdWord      bArith;      // B as the adder sees it
  tAdWord      sum;
  logic [1:0]  cinTotal;    // Subtract one plus carry-in, up to two
  logic        isSub;
  logic        isArith;
  logic [37:0] lowSum;      // Bits 0..35 with room above for the carry

  always_comb begin
    case (adaSel)
      adaAR:   aOp = ar;
      adaARX:  aOp = arx;
      adaMQ:   aOp = mq;
      default: aOp = pc;
    endcase
  end

  assign aExt = {{2{aOp[0]}}, aOp};               // Sign extend into guard bits

  always_comb begin
    case (adbSel)
      adbBR:   bExt = {{2{br[0]}}, br};
      adbBRx2: bExt = {br[0], br, 1'b0};          // Sign moves up into bit -1
      adbFM:   bExt = {{2{fmData[0]}}, fmData};
      default: bExt = {{2{arx[0]}}, arx};
    endcase
  end

  assign isSub   = (adFunc == adAMinusB);
  assign isArith = isSub || (adFunc == adAPlusB);

  // A - B is done as A + ~B + 1
  assign bArith   = isSub ? ~bExt : bExt;
  assign cinTotal = {1'b0, isSub} + {1'b0, adCarryIn & isArith};

  assign sum    = aExt + bArith + {36'd0, cinTotal};
  assign lowSum = {2'b00, aExt[0:35]} + {2'b00, bArith[0:35]} + {36'd0, cinTotal};

  always_comb begin
    case (adFunc)
      adA:       ad = aExt;
      adB:       ad = bExt;
      adAPlusB:  ad = sum;
      adAMinusB: ad = sum;
      adAnd:     ad = aExt & bExt;
      adOr:      ad = aExt | bExt;
      adXor:     ad = aExt ^ bExt;
      default:   ad = '0;                         // adZero
    endcase
  end

  // Carry out of bit 0, only meaningful for add and subtract
  assign adCarryOut = isArith & (|lowSum[37:36]);

endmodule

`default_nettype wire

// File: source/edpFastMem.sv
`default_nettype none

module edpFastMem import edpPkg::*; #(
  parameter int fmBlocks = 8
) (
  input  logic                   clk,
  input  logic [fmBlockBits-1:0] fmBlock,
  input  logic [fmAdrBits-1:0]   fmAdr,
  input  tWord                   writeData,
  input  logic                   fmWriteLeft,
  input  logic                   fmWriteRight,
  output tWord                   fmData
);

  localparam int fmWords = fmBlocks * fmAccs;

  tWord mem [fmWords];                            // ACs keep their contents through rst

  logic [fmBlockBits+fmAdrBits-1:0] adr;

  assign adr = {fmBlock, fmAdr};                  // Block selects a group of 16 ACs

  // Each half has its own write strobe
  always_ff @(posedge clk) begin
    if (fmWriteLeft) begin
      mem[adr][0:halfBits-1] <= leftHalf(writeData);
    end
    if (fmWriteRight) begin
      mem[adr][halfBits:wordBits-1] <= rightHalf(writeData);
    end
  end

  assign fmData = mem[adr];                       // Asynchronous read

endmodule

`default_nettype wire

// File: source/edpPkg.sv
`default_nettype none

package edpPkg;

  localparam int wordBits    = 36;
  localparam int halfBits    = 18;
  localparam int fmBlockBits = 3;                 // Block number width
  localparam int fmAdrBits   = 4;                 // Accumulator number width
  localparam int fmAccs      = 1 << fmAdrBits;    // 16 ACs per block

  // Bit 0 is the sign, bit 35 the LSB
  typedef logic [0:wordBits-1]  tWord;
  typedef logic [-2:wordBits-1] tAdWord;          // Two guard bits above bit 0
  typedef logic [0:halfBits-1]  tHalf;

  typedef enum logic [2:0] {
    adA       = 3'd0,
    adB       = 3'd1,
    adAPlusB  = 3'd2,
    adAMinusB = 3'd3,
    adAnd     = 3'd4,
    adOr      = 3'd5,
    adXor     = 3'd6,
    adZero    = 3'd7
  } tAdFunc;

  typedef enum logic [1:0] {
    adaAR  = 2'd0,
    adaARX = 2'd1,
    adaMQ  = 2'd2,
    adaPC  = 2'd3
  } tAdaSel;

  typedef enum logic [1:0] {
    adbBR   = 2'd0,
    adbBRx2 = 2'd1,                               // BR shifted left one place
    adbFM   = 2'd2,
    adbARX  = 2'd3
  } tAdbSel;

  // Source of one half of AR or ARX
  typedef enum logic [2:0] {
    arHold  = 3'd0,
    arAD    = 3'd1,
    arCache = 3'd2,
    arFM    = 3'd3,
    arEbus  = 3'd4,
    arClr   = 3'd5
  } tArSel;

  typedef enum logic [1:0] {
    mqHold  = 2'd0,
    mqAD    = 2'd1,
    mqShift = 2'd2,
    mqClr   = 2'd3
  } tMqSel;

  function automatic tHalf leftHalf(tWord w);
    return w[0:halfBits-1];
  endfunction

  function automatic tHalf rightHalf(tWord w);
    return w[halfBits:wordBits-1];
  endfunction

endpackage

`default_nettype wire

// File: source/edpWorkRegs.sv
`default_nettype none

module edpWorkRegs import edpPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  tArSel  arlSel,
  input  tArSel  arrSel,
  input  tArSel  arxlSel,
  input  tArSel  arxrSel,
  input  logic   brLoad,
  input  logic   brxLoad,
  input  tMqSel  mqSel,
  input  tAdWord ad,
  input  tWord   fmData,
  input  tWord   cacheData,
  input  tWord   ebusIn,
  output tWord   ar,
  output tWord   arx,
  output tWord   br,
  output tWord   brx,
  output tWord   mq
);

  tWord adWord;                                   // AD without the guard bits
  tWord arNext;
  tWord arxNext;

  assign adWord = ad[0:35];

  // One half of AR or ARX, picked from the matching half of each source
  function automatic tHalf pickHalf(
    tArSel sel,
    tHalf  cur,
    tHalf  adH,
    tHalf  cacheH,
    tHalf  fmH,
    tHalf  ebusH
  );
    case (sel)
      arAD:    return adH;
      arCache: return cacheH;
      arFM:    return fmH;
      arEbus:  return ebusH;
      arClr:   return '0;
      default: return cur;                        // arHold and unused codes
    endcase
  endfunction

  assign arNext = {
    pickHalf(arlSel, leftHalf(ar), leftHalf(adWord), leftHalf(cacheData),
             leftHalf(fmData), leftHalf(ebusIn)),
    pickHalf(arrSel, rightHalf(ar), rightHalf(adWord), rightHalf(cacheData),
             rightHalf(fmData), rightHalf(ebusIn))
  };

  assign arxNext = {
    pickHalf(arxlSel, leftHalf(arx), leftHalf(adWord), leftHalf(cacheData),
             leftHalf(fmData), leftHalf(ebusIn)),
    pickHalf(arxrSel, rightHalf(arx), rightHalf(adWord), rightHalf(cacheData),
             rightHalf(fmData), rightHalf(ebusIn))
  };

  always_ff @(posedge clk) begin
    if (rst) begin
      ar  <= '0;
      arx <= '0;
    end else begin
      ar  <= arNext;
      arx <= arxNext;
    end
  end

  // BR and BRX copy the values AR and ARX held before this edge
  always_ff @(posedge clk) begin
    if (rst) begin
      br <= '0;
    end else if (brLoad) begin
      br <= ar;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      brx <= '0;
    end else if (brxLoad) begin
      brx <= arx;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mq <= '0;
    end else begin
      case (mqSel)
        mqAD:    mq <= adWord;
        mqShift: mq <= {adWord[35], mq[0:34]};    // AD bit 35 fills from the top
        mqClr:   mq <= '0;
        default: mq <= mq;                        // mqHold
      endcase
    end
  end

endmodule

`default_nettype wire
